// ==== Makefile ====
# Verilator build and run of the pulse generator testbench

SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal -j 0
TOP      = pulseGenTb
FILELIST = compile.f
OBJDIR   = obj_dir
LOG      = sim.log

SRCS = $(wildcard source/*.sv) $(wildcard testbench/*.sv) $(wildcard testbench/*.svh)
BIN  = $(OBJDIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx "Finished with no errors" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== compile.f ====
+incdir+testbench
source/pulsePkg.sv
source/tickPrescaler.sv
source/pulseChannel.sv
source/axiLiteRegs.sv
source/pulseGenTop.sv
testbench/pulseGenTb.sv

// ==== source/axiLiteRegs.sv ====
/*
  AXI4-Lite slave register file for the pulse generator bank.
  Holds the enable word and per-channel half-period and start level,
  hands them to the channels as chCfg and returns live output levels.
*/
`timescale 1ns/100ps

module axiLiteRegs #(
    parameter int pNumCh = 4
)(
    input  logic               iCLK,
    input  logic               iRST,
    input  pulsePkg::axiWrReqT wrReq,
    output pulsePkg::axiWrRspT wrRsp,
    input  pulsePkg::axiRdReqT rdReq,
    output pulsePkg::axiRdRspT rdRsp,
    input  logic [pNumCh-1:0]  pulseLevel,
    output pulsePkg::chCfgT    chCfg [pNumCh]
);
    import pulsePkg::*;

    // ------------------------------------------------------------------
    // storage
    // ------------------------------------------------------------------
    logic [pNumCh-1:0]   ctrlReg;
    logic [cPeriodW-1:0] halfPeriodReg [pNumCh];
    logic                startLevelReg [pNumCh];

    // write side
    logic              awRdy;
    logic              wRdy;
    logic              bValid;
    logic [1:0]        bResp;
    logic              awHeld;
    logic              wHeld;
    logic [cAddrW-1:0] awAddrQ;
    logic [cDataW-1:0] wDataQ;
    logic [cStrbW-1:0] wStrbQ;

    logic              awFire;
    logic              wFire;
    logic              doWrite;
    logic [cAddrW-1:0] wrAddr;
    logic [cDataW-1:0] wrData;
    logic [cDataW-1:0] wrMask;
    logic              wrCtrlHit;
    logic [pNumCh-1:0] wrChHit;
    logic              wrOk;
    logic [pNumCh-1:0] ctrlNew;
    logic [cStartBit:0] chWordNew [pNumCh];

    logic awHeldNext;
    logic wHeldNext;
    logic bValidNext;

    // read side
    logic              arRdy;
    logic              rValid;
    logic [cDataW-1:0] rData;
    logic [1:0]        rResp;
    logic              arFire;
    logic [cDataW-1:0] rdDataC;
    logic              rdOkC;
    logic              rValidNext;

    // byte strobes to a bit mask
    function automatic logic [cDataW-1:0] strbMask(input logic [cStrbW-1:0] strb);
        logic [cDataW-1:0] mask;
        for (int b = 0; b < cStrbW; b++)
        begin
            mask[8*b +: 8] = {8{strb[b]}};
        end
        return mask;
    endfunction

    // offset of channel idx
    function automatic logic [cAddrW-1:0] chAddr(input int idx);
        return cRegChBase + cAddrW'(4 * idx);
    endfunction

    // ------------------------------------------------------------------
    // write path
    // ------------------------------------------------------------------
    always_comb
    begin
        awFire  = wrReq.awvalid && awRdy;
        wFire   = wrReq.wvalid && wRdy;
        // bypass the holding regs when the beat lands this cycle
        wrAddr  = awFire ? wrReq.awaddr : awAddrQ;
        wrData  = wFire ? wrReq.wdata : wDataQ;
        wrMask  = strbMask(wFire ? wrReq.wstrb : wStrbQ);
        doWrite = (awFire || awHeld) && (wFire || wHeld);

        // address decode
        wrCtrlHit = (wrAddr == cRegCtrl);
        for (int i = 0; i < pNumCh; i++)
        begin
            wrChHit[i] = (wrAddr == chAddr(i));
        end
        wrOk = wrCtrlHit || (wrAddr == cRegStatus) || (|wrChHit);

        // strobe merge, only stored bits survive
        ctrlNew = (ctrlReg & ~wrMask[pNumCh-1:0]) | (wrData[pNumCh-1:0] & wrMask[pNumCh-1:0]);
        for (int i = 0; i < pNumCh; i++)
        begin
            chWordNew[i] = ({startLevelReg[i], halfPeriodReg[i]} & ~wrMask[cStartBit:0])
                         | (wrData[cStartBit:0] & wrMask[cStartBit:0]);
        end

        // handshake next state
        awHeldNext = (awHeld || awFire) && !doWrite;
        wHeldNext  = (wHeld || wFire) && !doWrite;
        bValidNext = doWrite || (bValid && !wrReq.bready);
    end

    always_ff @(posedge iCLK)
    begin
        if (iRST)
        begin
            awRdy  <= 1'b0;
            wRdy   <= 1'b0;
            bValid <= 1'b0;
            bResp  <= cRespOkay;
            awHeld <= 1'b0;
            wHeld  <= 1'b0;
        end
        else
        begin
            awHeld <= awHeldNext;
            wHeld  <= wHeldNext;
            bValid <= bValidNext;
            // no new beats while one is held or B is pending
            awRdy  <= !awHeldNext && !bValidNext;
            wRdy   <= !wHeldNext && !bValidNext;
            if (doWrite)
            begin
                bResp <= wrOk ? cRespOkay : cRespSlvErr;
            end
        end
    end

    // beat payloads
    always_ff @(posedge iCLK)
    begin
        if (awFire)
        begin
            awAddrQ <= wrReq.awaddr;
        end
        if (wFire)
        begin
            wDataQ <= wrReq.wdata;
            wStrbQ <= wrReq.wstrb;
        end
    end

    // register update, visible when bvalid rises
    always_ff @(posedge iCLK)
    begin
        if (iRST)
        begin
            ctrlReg <= '0;
            for (int i = 0; i < pNumCh; i++)
            begin
                halfPeriodReg[i] <= '0;
                startLevelReg[i] <= 1'b0;
            end
        end
        else if (doWrite)
        begin
            if (wrCtrlHit)
            begin
                ctrlReg <= ctrlNew;
            end
            for (int i = 0; i < pNumCh; i++)
            begin
                if (wrChHit[i])
                begin
                    {startLevelReg[i], halfPeriodReg[i]} <= chWordNew[i];
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // read path
    // ------------------------------------------------------------------
    always_comb
    begin
        arFire  = rdReq.arvalid && arRdy;
        rdDataC = '0;
        rdOkC   = 1'b1;
        if (rdReq.araddr == cRegCtrl)
        begin
            rdDataC[pNumCh-1:0] = ctrlReg;
        end
        else if (rdReq.araddr == cRegStatus)
        begin
            rdDataC[pNumCh-1:0] = pulseLevel;
        end
        else
        begin
            // unmapped unless a channel matches
            rdOkC = 1'b0;
            for (int i = 0; i < pNumCh; i++)
            begin
                if (rdReq.araddr == chAddr(i))
                begin
                    rdOkC                  = 1'b1;
                    rdDataC[cPeriodW-1:0]  = halfPeriodReg[i];
                    rdDataC[cStartBit]     = startLevelReg[i];
                end
            end
        end
        rValidNext = arFire || (rValid && !rdReq.rready);
    end

    always_ff @(posedge iCLK)
    begin
        if (iRST)
        begin
            arRdy  <= 1'b0;
            rValid <= 1'b0;
            rResp  <= cRespOkay;
        end
        else
        begin
            rValid <= rValidNext;
            arRdy  <= !rValidNext;
            if (arFire)
            begin
                rResp <= rdOkC ? cRespOkay : cRespSlvErr;
            end
        end
    end

    // read data, sampled at the AR handshake
    always_ff @(posedge iCLK)
    begin
        if (arFire)
        begin
            rData <= rdDataC;
        end
    end

    // ------------------------------------------------------------------
    // outputs
    // ------------------------------------------------------------------
    always_comb
    begin
        wrRsp.awready = awRdy;
        wrRsp.wready  = wRdy;
        wrRsp.bvalid  = bValid;
        wrRsp.bresp   = bResp;
        rdRsp.arready = arRdy;
        rdRsp.rvalid  = rValid;
        rdRsp.rdata   = rData;
        rdRsp.rresp   = rResp;
        for (int i = 0; i < pNumCh; i++)
        begin
            chCfg[i].halfPeriod = halfPeriodReg[i];
            chCfg[i].startLevel = startLevelReg[i];
            chCfg[i].enable     = ctrlReg[i];
        end
    end

    // B and R held with stable payload until taken
    assert property (@(posedge iCLK) disable iff (iRST)
        bValid && !wrReq.bready |=> bValid && $stable(bResp));
    assert property (@(posedge iCLK) disable iff (iRST)
        rValid && !rdReq.rready |=> rValid && $stable(rData) && $stable(rResp));

endmodule

// ==== source/pulseChannel.sv ====
/*
  One square-wave channel. Counts prescaler ticks up to halfPeriod
  and toggles its output, restarting from startLevel on enable.
*/
`timescale 1ns/100ps

module pulseChannel (
    input  logic            iCLK,
    input  logic            iRST,
    input  logic            tick,
    input  pulsePkg::chCfgT cfg,
    output logic            pulse
);
    import pulsePkg::*;

    // ------------------------------------------------------------------
    // tick counter
    // ------------------------------------------------------------------
    logic [cPeriodW-1:0] tickCnt;
    logic [cPeriodW-1:0] tickCntInc;
    logic                periodOn;
    logic                halfDone;
    logic                pulseQ;

    assign tickCntInc = tickCnt + 1'b1;
    // halfPeriod 0 means hold the start level
    assign periodOn   = (cfg.halfPeriod != '0);
    // the H-th tick of this half period
    assign halfDone   = tick && periodOn && (tickCntInc == cfg.halfPeriod);

    always_ff @(posedge iCLK)
    begin
        if (iRST)
        begin
            tickCnt <= '0;
        end
        else if (!cfg.enable)
        begin
            // parked, so enable always starts a fresh half period
            tickCnt <= '0;
        end
        else if (halfDone)
        begin
            tickCnt <= '0;
        end
        else if (tick && periodOn)
        begin
            tickCnt <= tickCntInc;
        end
    end

    // ------------------------------------------------------------------
    // output toggle
    // ------------------------------------------------------------------
    always_ff @(posedge iCLK)
    begin
        if (iRST)
        begin
            pulseQ <= 1'b0;
        end
        else if (!cfg.enable)
        begin
            // follow start level while disabled
            pulseQ <= cfg.startLevel;
        end
        else if (halfDone)
        begin
            pulseQ <= ~pulseQ;
        end
    end

    assign pulse = pulseQ;

    // disabled and start level steady, so the output is steady
    assert property (@(posedge iCLK) disable iff (iRST)
        (!cfg.enable ##1 (!cfg.enable && $stable(cfg.startLevel))) |=> $stable(pulse));

endmodule

// ==== source/pulseGenTop.sv ====
/*
  Top of the pulse generator bank. Connects the AXI4-Lite register
  block, the shared tick prescaler and pNumCh pulse channels.
*/
`timescale 1ns/100ps

module pulseGenTop #(
    parameter int pNumCh    = 4,
    parameter int pPrescale = 5
)(
    input  logic               iCLK,
    input  logic               iRST,
    input  pulsePkg::axiWrReqT wrReq,
    output pulsePkg::axiWrRspT wrRsp,
    input  pulsePkg::axiRdReqT rdReq,
    output pulsePkg::axiRdRspT rdRsp,
    output logic [pNumCh-1:0]  pulseOut
);
    import pulsePkg::*;

    // channel count must fit the register map
    if (pNumCh < 1 || pNumCh > cMaxCh)
    begin : gBadNumCh
        $fatal(1, "pNumCh must be 1 to %0d, got %0d", cMaxCh, pNumCh);
    end

    // ------------------------------------------------------------------
    // internal nets
    // ------------------------------------------------------------------
    chCfgT chCfg [pNumCh];
    logic  tick;

    // register block, status reads back the live outputs
    axiLiteRegs #(
        .pNumCh     (pNumCh)
    ) regs0 (
        .iCLK       (iCLK),
        .iRST       (iRST),
        .wrReq      (wrReq),
        .wrRsp      (wrRsp),
        .rdReq      (rdReq),
        .rdRsp      (rdRsp),
        .pulseLevel (pulseOut),
        .chCfg      (chCfg)
    );

    // one tick source for every channel
    tickPrescaler #(
        .pPrescale  (pPrescale)
    ) presc0 (
        .iCLK       (iCLK),
        .iRST       (iRST),
        .tick       (tick)
    );

    // ------------------------------------------------------------------
    // channel array
    // ------------------------------------------------------------------
    for (genvar i = 0; i < pNumCh; i++)
    begin : gCh
        pulseChannel ch (
            .iCLK   (iCLK),
            .iRST   (iRST),
            .tick   (tick),
            .cfg    (chCfg[i]),
            .pulse  (pulseOut[i])
        );
    end

endmodule

// ==== source/pulsePkg.sv ====
/*
  Shared widths, register map and bus structs for the pulse generator bank.
  Each module imports this package inside its body.
*/
package pulsePkg;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------
    localparam int cAddrW   = 8;
    localparam int cDataW   = 32;
    localparam int cStrbW   = cDataW / 8;
    localparam int cPeriodW = 16;
    localparam int cMaxCh   = 8;

    // startLevel sits right above the half-period field
    localparam int cStartBit = cPeriodW;

    // register map, channel n at cRegChBase + 4*n
    localparam logic [cAddrW-1:0] cRegCtrl   = 8'h00;
    localparam logic [cAddrW-1:0] cRegStatus = 8'h04;
    localparam logic [cAddrW-1:0] cRegChBase = 8'h10;

    // response codes in use
    localparam logic [1:0] cRespOkay   = 2'b00;
    localparam logic [1:0] cRespSlvErr = 2'b10;

    // ------------------------------------------------------------------
    // structs
    // ------------------------------------------------------------------
    // one channel's settings
    typedef struct packed {
        logic [cPeriodW-1:0] halfPeriod;
        logic                startLevel;
        logic                enable;
    } chCfgT;

    // write address, write data and B ready from the master
    typedef struct packed {
        logic              awvalid;
        logic [cAddrW-1:0] awaddr;
        logic              wvalid;
        logic [cDataW-1:0] wdata;
        logic [cStrbW-1:0] wstrb;
        logic              bready;
    } axiWrReqT;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic [1:0] bresp;
    } axiWrRspT;

    typedef struct packed {
        logic              arvalid;
        logic [cAddrW-1:0] araddr;
        logic              rready;
    } axiRdReqT;

    typedef struct packed {
        logic              arready;
        logic              rvalid;
        logic [cDataW-1:0] rdata;
        logic [1:0]        rresp;
    } axiRdRspT;

endpackage

// ==== source/tickPrescaler.sv ====
/*
  Free-running clock-enable divider shared by all pulse channels.
  Issues a one-cycle tick every pPrescale clocks.
*/
`timescale 1ns/100ps

module tickPrescaler #(
    parameter int pPrescale = 5
)(
    input  logic iCLK,
    input  logic iRST,
    output logic tick
);

    // divide by less than 2 would give a constant tick
    if (pPrescale < 2)
    begin : gBadPrescale
        $fatal(1, "pPrescale must be at least 2, got %0d", pPrescale);
    end

    // ------------------------------------------------------------------
    // divider counter
    // ------------------------------------------------------------------
    localparam int lpCntW = $clog2(pPrescale);
    localparam logic [lpCntW-1:0] lpTop = lpCntW'(pPrescale - 1);

    logic [lpCntW-1:0] divCnt;
    logic              atTop;

    assign atTop = (divCnt == lpTop);

    always_ff @(posedge iCLK)
    begin
        if (iRST)
        begin
            divCnt <= '0;
            tick   <= 1'b0;
        end
        else
        begin
            // wrap at the top, registered tick follows
            divCnt <= atTop ? '0 : divCnt + 1'b1;
            tick   <= atTop;
        end
    end

endmodule

// ==== testbench/axiLiteTasks.svh ====
/*
  AXI4-Lite master tasks and result checks for the pulse generator testbench.
  Included into the testbench module body. Drives wrReq and rdReq on the
  falling clock edge and samples the DUT responses there.
*/
`ifndef AXI_LITE_TASKS_SVH
`define AXI_LITE_TASKS_SVH

// ----------------------------------------------------------------------
// result checks
// ----------------------------------------------------------------------
task automatic checkValue(input string name, input logic [31:0] expVal,
                          input logic [31:0] actVal);
    checkCnt++;
    if (actVal !== expVal)
    begin
        errCnt++;
        $display("ERR %s expected 0x%0h actual 0x%0h", name, expVal, actVal);
    end
endtask

// failures with no single expected value
task automatic reportFailure(input string msg);
    errCnt++;
    $display("%s: %s", curTest, msg);
endtask

// ----------------------------------------------------------------------
// write transaction, B held off for bDelay cycles
// ----------------------------------------------------------------------
task automatic writeReg(input logic [7:0] addr, input logic [31:0] data,
                        input logic [3:0] strb, input int bDelay,
                        output logic [1:0] resp);
    int   waitCnt;
    logic awHit;
    logic wHit;
    @(negedge iCLK);
    wrReq.awvalid = 1'b1;
    wrReq.awaddr  = addr;
    wrReq.wvalid  = 1'b1;
    wrReq.wdata   = data;
    wrReq.wstrb   = strb;
    wrReq.bready  = 1'b0;
    waitCnt       = 0;
    // AW and W may be taken in either order
    while ((wrReq.awvalid || wrReq.wvalid) && waitCnt < cHandshakeLimit)
    begin
        awHit = wrReq.awvalid && wrRsp.awready;
        wHit  = wrReq.wvalid && wrRsp.wready;
        @(negedge iCLK);
        waitCnt++;
        if (awHit)
        begin
            wrReq.awvalid = 1'b0;
        end
        if (wHit)
        begin
            wrReq.wvalid = 1'b0;
        end
    end
    while (!wrRsp.bvalid && waitCnt < cHandshakeLimit)
    begin
        @(negedge iCLK);
        waitCnt++;
    end
    if (!wrRsp.bvalid)
    begin
        reportFailure($sformatf("no write response for address 0x%02h", addr));
        wrReq.awvalid = 1'b0;
        wrReq.wvalid  = 1'b0;
        resp          = 2'b11;
        return;
    end
    // back-pressure, bvalid has to wait for us
    repeat (bDelay)
    begin
        @(negedge iCLK);
        if (!wrRsp.bvalid)
        begin
            reportFailure($sformatf("bvalid dropped before bready, address 0x%02h", addr));
        end
    end
    wrReq.bready = 1'b1;
    bCycle       = cycleCnt + 1;
    resp         = wrRsp.bresp;
    @(negedge iCLK);
    wrReq.bready = 1'b0;
endtask

// ----------------------------------------------------------------------
// read transaction, snap is pulseOut at the AR handshake
// ----------------------------------------------------------------------
task automatic readReg(input logic [7:0] addr, input int rDelay,
                       output logic [31:0] data, output logic [1:0] resp,
                       output logic [cNumCh-1:0] snap);
    int waitCnt;
    @(negedge iCLK);
    rdReq.arvalid = 1'b1;
    rdReq.araddr  = addr;
    rdReq.rready  = 1'b0;
    waitCnt       = 0;
    while (!rdRsp.arready && waitCnt < cHandshakeLimit)
    begin
        @(negedge iCLK);
        waitCnt++;
    end
    if (!rdRsp.arready)
    begin
        reportFailure($sformatf("arready never rose for address 0x%02h", addr));
        rdReq.arvalid = 1'b0;
        data          = '0;
        resp          = 2'b11;
        snap          = '0;
        return;
    end
    // level seen by the DUT at the next rising edge
    snap = pulseOut;
    @(negedge iCLK);
    rdReq.arvalid = 1'b0;
    if (!rdRsp.rvalid)
    begin
        reportFailure($sformatf("rvalid late for address 0x%02h", addr));
    end
    repeat (rDelay)
    begin
        @(negedge iCLK);
        if (!rdRsp.rvalid)
        begin
            reportFailure($sformatf("rvalid dropped before rready, address 0x%02h", addr));
        end
    end
    rdReq.rready = 1'b1;
    data         = rdRsp.rdata;
    resp         = rdRsp.rresp;
    @(negedge iCLK);
    rdReq.rready = 1'b0;
endtask

`endif

// ==== testbench/pulseGenTb.sv ====
/*
  Testbench for the pulse generator bank. Runs register access, pulse
  interval, start level and back-pressure tests against a register model
  and reports one line per test plus a closing count line.
*/
`timescale 1ns/100ps

module pulseGenTb;
    import pulsePkg::*;

    localparam int cNumCh          = 4;
    localparam int cPrescale       = 5;
    localparam int cHalfClkNs      = 20;
    localparam int cClkPeriodNs    = 2 * cHalfClkNs;
    localparam int cResetCyc       = 16;
    localparam int cHandshakeLimit = 64;
    localparam int cEdgeLimit      = 600;

    // planned test lengths in clocks, watchdog gets 50% on top
    localparam int cPlannedCyc  = cResetCyc + 100 + 600 + 800 + 1000 + 800;
    localparam int cWatchdogCyc = cPlannedCyc * 3 / 2;

    logic              iCLK;
    logic              iRST;
    axiWrReqT          wrReq;
    axiWrRspT          wrRsp;
    axiRdReqT          rdReq;
    axiRdRspT          rdRsp;
    logic [cNumCh-1:0] pulseOut;

    int    errCnt       = 0;
    int    checkCnt     = 0;
    int    cycleCnt     = 0;
    int    bCycle       = 0;
    int    testCnt      = 0;
    int    testFailCnt  = 0;
    int    testErrStart = 0;
    string curTest      = "reset";

    // register model
    logic [cNumCh-1:0] mCtrl;
    logic [15:0]       mHalf [cNumCh];
    logic              mStart [cNumCh];

    // edge monitor state
    logic armed [cNumCh];
    int   edgeCnt [cNumCh];
    int   lastEdge [cNumCh];
    logic prevLevel [cNumCh];

    `include "axiLiteTasks.svh"

    pulseGenTop #(
        .pNumCh    (cNumCh),
        .pPrescale (cPrescale)
    ) dut0 (
        .iCLK      (iCLK),
        .iRST      (iRST),
        .wrReq     (wrReq),
        .wrRsp     (wrRsp),
        .rdReq     (rdReq),
        .rdRsp     (rdRsp),
        .pulseOut  (pulseOut)
    );

    initial
    begin
        iCLK = 1'b0;
        forever #(cHalfClkNs) iCLK = ~iCLK;
    end

    always @(posedge iCLK)
    begin
        cycleCnt <= cycleCnt + 1;
    end

    initial
    begin
        #(cWatchdogCyc * cClkPeriodNs);
        $display("timeout: test did not finish, running %s", curTest);
        $display("Finished with errors");
        $finish;
    end

    // ------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------
    function automatic int expectedInterval(input int halfPeriod);
        return halfPeriod * cPrescale;
    endfunction

    function automatic logic [7:0] channelOffset(input int idx);
        return 8'h10 + 8'(4 * idx);
    endfunction

    function automatic logic [1:0] expectedResp(input logic [7:0] addr);
        if (addr == 8'h00 || addr == 8'h04)
        begin
            return 2'b00;
        end
        for (int i = 0; i < cNumCh; i++)
        begin
            if (addr == channelOffset(i))
            begin
                return 2'b00;
            end
        end
        return 2'b10;
    endfunction

    // status comes from the level seen at the AR handshake
    function automatic logic [31:0] expectedRead(input logic [7:0] addr,
                                                 input logic [cNumCh-1:0] level);
        logic [31:0] data;
        data = '0;
        if (addr == 8'h00)
        begin
            data[cNumCh-1:0] = mCtrl;
        end
        else if (addr == 8'h04)
        begin
            data[cNumCh-1:0] = level;
        end
        for (int i = 0; i < cNumCh; i++)
        begin
            if (addr == channelOffset(i))
            begin
                data[15:0] = mHalf[i];
                data[16]   = mStart[i];
            end
        end
        return data;
    endfunction

    // byte strobes applied to stored fields only
    task automatic modelWrite(input logic [7:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        logic [31:0] mask;
        logic [31:0] word;
        for (int b = 0; b < 4; b++)
        begin
            mask[8*b +: 8] = {8{strb[b]}};
        end
        if (addr == 8'h00)
        begin
            mCtrl = (mCtrl & ~mask[cNumCh-1:0]) | (data[cNumCh-1:0] & mask[cNumCh-1:0]);
        end
        for (int i = 0; i < cNumCh; i++)
        begin
            if (addr == channelOffset(i))
            begin
                word      = {15'b0, mStart[i], mHalf[i]};
                word      = (word & ~mask) | (data & mask);
                mHalf[i]  = word[15:0];
                mStart[i] = word[16];
            end
        end
    endtask

    task automatic writeChecked(input logic [7:0] addr, input logic [31:0] data,
                                input logic [3:0] strb, input int bDelay);
        logic [1:0] resp;
        writeReg(addr, data, strb, bDelay, resp);
        checkValue($sformatf("%s bresp 0x%02h", curTest, addr), expectedResp(addr), resp);
        modelWrite(addr, data, strb);
    endtask

    task automatic readChecked(input logic [7:0] addr, input int rDelay);
        logic [31:0]       data;
        logic [1:0]        resp;
        logic [cNumCh-1:0] snap;
        readReg(addr, rDelay, data, resp, snap);
        checkValue($sformatf("%s read 0x%02h", curTest, addr), expectedRead(addr, snap), data);
        checkValue($sformatf("%s rresp 0x%02h", curTest, addr), expectedResp(addr), resp);
    endtask

    function automatic logic allChannelsReached(input int count);
        for (int i = 0; i < cNumCh; i++)
        begin
            if (edgeCnt[i] < count)
            begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic startTest(input string name);
        curTest      = name;
        testErrStart = errCnt;
    endtask

    task automatic finishTest();
        testCnt++;
        if (errCnt == testErrStart)
        begin
            $display("test %s: pass", curTest);
        end
        else
        begin
            testFailCnt++;
            $display("test %s: fail, %0d errors", curTest, errCnt - testErrStart);
        end
    endtask

    // ------------------------------------------------------------------
    // edge monitor, one process per channel
    // ------------------------------------------------------------------
    for (genvar g = 0; g < cNumCh; g++)
    begin : gMon
        always @(negedge iCLK)
        begin
            if (armed[g] && pulseOut[g] !== prevLevel[g])
            begin
                if (edgeCnt[g] == 0)
                begin
                    // first edge only has an upper bound
                    if (cycleCnt - bCycle > expectedInterval(mHalf[g]) + 1)
                    begin
                        reportFailure($sformatf(
                            "first edge of channel %0d came %0d cycles after enable, bound %0d",
                            g, cycleCnt - bCycle, expectedInterval(mHalf[g]) + 1));
                    end
                end
                else
                begin
                    checkValue($sformatf("%s ch%0d interval", curTest, g),
                               expectedInterval(mHalf[g]), cycleCnt - lastEdge[g]);
                end
                edgeCnt[g]++;
                lastEdge[g] = cycleCnt;
            end
            prevLevel[g] = pulseOut[g];
        end
    end

    // ------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------
    initial
    begin
        logic [7:0] badAddr [5];
        logic [3:0] strb;
        int         waitCnt;
        int         changes;
        void'($urandom(63));
        iRST    = 1'b1;
        wrReq   = '0;
        rdReq   = '0;
        mCtrl   = '0;
        for (int i = 0; i < cNumCh; i++)
        begin
            mHalf[i]     = '0;
            mStart[i]    = 1'b0;
            armed[i]     = 1'b0;
            edgeCnt[i]   = 0;
            lastEdge[i]  = 0;
            prevLevel[i] = 1'b0;
        end
        badAddr = '{8'h08, 8'h0C, channelOffset(5), 8'h40, 8'hFC};
        repeat (cResetCyc) @(posedge iCLK);
        @(negedge iCLK);
        iRST = 1'b0;

        startTest("resetState");
        checkValue("resetState pulseOut", 0, pulseOut);
        readChecked(8'h00, 0);
        readChecked(8'h04, 0);
        for (int i = 0; i < cNumCh; i++)
        begin
            readChecked(channelOffset(i), 0);
        end
        finishTest();

        startTest("registerAccess");
        for (int i = 0; i < cNumCh; i++)
        begin
            // odd channels get partial strobes
            strb = (i % 2 == 0) ? 4'hF : 4'($urandom_range(14, 1));
            writeChecked(channelOffset(i), $urandom, strb, 0);
            readChecked(channelOffset(i), 0);
        end
        for (int k = 0; k < 5; k++)
        begin
            writeChecked(badAddr[k], $urandom, 4'hF, 0);
            readChecked(badAddr[k], 0);
        end
        for (int i = 0; i < cNumCh; i++)
        begin
            readChecked(channelOffset(i), 0);
        end
        finishTest();

        startTest("pulseIntervals");
        for (int i = 0; i < cNumCh; i++)
        begin
            writeChecked(channelOffset(i),
                         {15'b0, 1'($urandom_range(1, 0)), 16'($urandom_range(20, 1))}, 4'hF, 0);
        end
        // arm before enabling so an early first edge is caught
        for (int i = 0; i < cNumCh; i++)
        begin
            edgeCnt[i]   = 0;
            prevLevel[i] = pulseOut[i];
            armed[i]     = 1'b1;
        end
        writeChecked(8'h00, 32'hF, 4'hF, 0);
        waitCnt = 0;
        while (!allChannelsReached(4) && waitCnt < cEdgeLimit)
        begin
            @(negedge iCLK);
            waitCnt++;
        end
        if (!allChannelsReached(4))
        begin
            reportFailure("too few output edges after enable");
        end
        finishTest();

        // channels keep running, the monitor still checks intervals
        startTest("statusBackPressure");
        for (int n = 0; n < 8; n++)
        begin
            readChecked(8'h04, $urandom_range(8, 0));
            readChecked(channelOffset(n % cNumCh), $urandom_range(8, 0));
            writeChecked(8'h00, 32'(mCtrl), 4'hF, $urandom_range(8, 0));
            writeChecked(8'h04, $urandom, 4'hF, $urandom_range(8, 0));
        end
        readChecked(8'h00, 3);
        finishTest();

        startTest("startLevelDisable");
        for (int i = 0; i < cNumCh; i++)
        begin
            armed[i] = 1'b0;
        end
        writeChecked(8'h00, 32'h0, 4'hF, 0);
        for (int i = 0; i < cNumCh; i++)
        begin
            checkValue($sformatf("%s ch%0d level when disabled", curTest, i),
                       mStart[i], pulseOut[i]);
        end
        writeChecked(channelOffset(0), 32'h0001_0007, 4'hF, 0);
        checkValue("startLevelDisable ch0 start level", 1, pulseOut[0]);
        readChecked(8'h04, 0);
        // run channel 1 from a high start, disable after its first edge
        writeChecked(channelOffset(1), 32'h0001_0014, 4'hF, 0);
        writeChecked(8'h00, 32'h2, 4'hF, 0);
        waitCnt = 0;
        while (pulseOut[1] !== 1'b0 && waitCnt < expectedInterval(20) + 2)
        begin
            @(negedge iCLK);
            waitCnt++;
        end
        if (pulseOut[1] !== 1'b0)
        begin
            reportFailure("channel 1 did not toggle after enable");
        end
        writeChecked(8'h00, 32'h0, 4'hF, 0);
        checkValue("startLevelDisable ch1 level after disable", mStart[1], pulseOut[1]);
        // halfPeriod 0 holds the start level
        writeChecked(channelOffset(2), 32'h0001_0000, 4'hF, 0);
        writeChecked(8'h00, 32'h4, 4'hF, 0);
        changes = 0;
        repeat (200)
        begin
            @(negedge iCLK);
            if (pulseOut[2] !== mStart[2])
            begin
                changes++;
            end
        end
        checkValue("startLevelDisable ch2 cycles off start level", 0, changes);
        finishTest();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 testCnt, testFailCnt, checkCnt, errCnt);
        if (errCnt == 0)
        begin
            $display("Finished with no errors");
        end
        else
        begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
